// ==== include/hc_params.svh ====
// Lines are 64 bits and addresses count in lines; queue depths must be powers of two
`ifndef HC_PARAMS_SVH
`define HC_PARAMS_SVH

// ========================================
// Host channel geometry
// ========================================
`define HC_LINE_BITS 64      // Stands in for a full cache line
`define HC_ADDR_BITS 32      // Line address, not byte address

// ========================================
// Accelerator sizing
// ========================================
`define HC_BUFFER_COUNT 2
`define HC_REQUEST_DEPTH 8   // Read request queue
`define HC_WRITE_DEPTH 16    // Write queue of command plus data

`define HC_CONTROL_START 32'h1

`endif

// ==== logic/hc_pkg.sv ====
// Host responses are in order with no tags; a request argument is either a size or an offset
`include "hc_params.svh"

package hc_pkg;

  // ========================================
  // Basic words
  // ========================================
  typedef logic [`HC_ADDR_BITS-1:0] t_addr;
  typedef logic [`HC_LINE_BITS-1:0] t_line;
  typedef logic [15:0] t_line_count;
  typedef logic [$clog2(`HC_BUFFER_COUNT)-1:0] t_buffer_id;
  typedef logic [$clog2(`HC_WRITE_DEPTH+1)-1:0] t_queue_count;

  // ========================================
  // Core requests
  // ========================================
  typedef enum logic [1:0] {
    e_REQUEST_NONE,
    e_REQUEST_READ_STREAM,
    e_REQUEST_WRITE_STREAM,
    e_REQUEST_WRITE_INDEXED
  } t_request_cmd;

  typedef union packed {
    t_line_count size;    // Stream read line count
    t_line_count offset;  // Indexed write line offset
  } t_request_arg;

  typedef struct packed {
    t_request_cmd cmd;
    t_buffer_id   id;
    t_request_arg arg;
  } t_request_control;

  typedef struct packed {
    t_addr       address;
    t_line_count size;
  } t_hc_buffer;

  // ========================================
  // Host channel
  // ========================================
  typedef struct packed {
    logic  valid;
    t_addr address;
  } t_c0_tx;

  typedef struct packed {
    logic  valid;
    t_addr address;
    t_line data;
  } t_c1_tx;

  typedef struct packed {
    logic  c0_alm_full;
    logic  c1_alm_full;
    logic  rsp_valid;
    t_line rsp_data;
  } t_host_rx;

  typedef struct packed {
    logic  valid;
    t_line data;
  } t_core_rx;

  typedef struct packed {
    t_queue_count count;
    logic         empty;
    logic         full;   // Count above depth minus 4
  } t_queue_status;

endpackage

// ==== logic/hc_fifo.sv ====
// Depth must be a power of two of at least 2 and an enqueue into a full queue is dropped
`timescale 1ns/1ns

module hc_fifo #(
  parameter int width = 8,
  parameter int depth = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [width-1:0]           enq_data,
  input  logic                       enq_en,
  output logic                       not_full,
  output logic [width-1:0]           deq_data,
  input  logic                       deq_en,
  output logic                       not_empty,
  output logic [$clog2(depth+1)-1:0] counter
);

  localparam int ptr_bits = $clog2(depth);

  logic [width-1:0]    mem [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic                do_enq;
  logic                do_deq;

  assign not_full  = (counter != depth);
  assign not_empty = (counter != '0);
  assign do_enq    = enq_en && not_full;
  assign do_deq    = deq_en && not_empty;
  assign deq_data  = mem[rd_ptr];  // Head entry is always visible

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      counter <= '0;
    end
    else begin
      if (do_enq) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      end
      if (do_deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10:   counter <= counter + 1'b1;
        2'b01:   counter <= counter - 1'b1;
        default: counter <= counter;  // Both or neither
      endcase
    end
  end

endmodule

// ==== logic/hc_requestor.sv ====
// Stream reads only, single-line requests, no write responses and host responses in order
`timescale 1ns/1ns
`include "hc_params.svh"

module hc_requestor (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     finish,
  input  logic [31:0]              hc_control,
  input  logic [`HC_ADDR_BITS-1:0] hc_dsm_base,
  input  hc_pkg::t_hc_buffer       hc_buffer [`HC_BUFFER_COUNT],
  input  hc_pkg::t_host_rx         host_rx,
  input  hc_pkg::t_request_control read_request,
  input  hc_pkg::t_request_control write_request,
  input  hc_pkg::t_line            write_data,
  output logic                     start,
  output hc_pkg::t_c0_tx           c0_tx,
  output hc_pkg::t_c1_tx           c1_tx,
  output hc_pkg::t_core_rx         core_rx,
  output hc_pkg::t_queue_status    read_status,
  output hc_pkg::t_queue_status    write_status
);

  import hc_pkg::*;

  typedef enum logic {rd_idle, rd_stream} t_rd_state;
  typedef enum logic [1:0] {wr_idle, wr_run, wr_finish, wr_done} t_wr_state;

  typedef struct packed {
    t_request_cmd cmd;
    t_buffer_id   id;
    t_line_count  offset;
    t_line        data;
  } t_write_entry;

  logic control_start;

  // Read queue
  logic                                   read_enq_en;
  logic                                   read_deq_en;
  logic                                   read_not_empty;
  logic [$clog2(`HC_REQUEST_DEPTH+1)-1:0] read_count;
  t_request_control                       read_head;

  // Write queue
  logic         write_enq_en;
  logic         write_deq_en;
  logic         write_not_empty;
  t_queue_count write_count;
  t_write_entry write_enq;
  t_write_entry write_head;

  // Read FSM
  t_rd_state        rd_state;
  t_rd_state        rd_next;
  t_request_control rd_req;
  t_addr            rd_count;
  t_queue_count     rd_outstanding;
  logic             rd_room;
  logic             rd_issue;
  logic             rd_last;
  logic             c0_valid;
  t_addr            c0_address;

  // Response forwarder
  logic  rsp_valid_q;
  t_line rsp_data_q;

  // Write FSM
  t_wr_state wr_state;
  t_wr_state wr_next;
  t_addr     wr_offset;
  logic      wr_issue;
  logic      dsm_issue;
  logic      c1_valid;
  t_addr     c1_address;
  t_line     c1_data;

  // ========================================
  // Start and queue status
  // ========================================
  assign control_start = (hc_control == `HC_CONTROL_START);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start        <= 1'b0;
      read_status  <= '0;
      write_status <= '0;
    end
    else begin
      start              <= control_start;
      read_status.count  <= t_queue_count'(read_count);
      read_status.empty  <= !read_not_empty;
      read_status.full   <= read_count > (`HC_REQUEST_DEPTH - 4);
      write_status.count <= write_count;
      write_status.empty <= !write_not_empty;
      write_status.full  <= write_count > (`HC_WRITE_DEPTH - 4);
    end
  end

  // ========================================
  // Request queues
  // ========================================
  assign read_enq_en  = (read_request.cmd == e_REQUEST_READ_STREAM);
  assign write_enq_en = (write_request.cmd == e_REQUEST_WRITE_STREAM) ||
                        (write_request.cmd == e_REQUEST_WRITE_INDEXED);
  assign write_enq    = '{cmd:    write_request.cmd,
                          id:     write_request.id,
                          offset: write_request.arg.offset,
                          data:   write_data};

  hc_fifo #(
    .width ($bits(t_request_control)),
    .depth (`HC_REQUEST_DEPTH)
  ) u_read_fifo (
    .clk       (clk),
    .reset     (reset),
    .enq_data  (read_request),
    .enq_en    (read_enq_en),
    .not_full  (),
    .deq_data  (read_head),
    .deq_en    (read_deq_en),
    .not_empty (read_not_empty),
    .counter   (read_count)
  );

  hc_fifo #(
    .width ($bits(t_write_entry)),
    .depth (`HC_WRITE_DEPTH)
  ) u_write_fifo (
    .clk       (clk),
    .reset     (reset),
    .enq_data  (write_enq),
    .enq_en    (write_enq_en),
    .not_full  (),
    .deq_data  (write_head),
    .deq_en    (write_deq_en),
    .not_empty (write_not_empty),
    .counter   (write_count)
  );

  // ========================================
  // Read FSM
  // ========================================
  assign read_deq_en = (rd_state == rd_idle) && read_not_empty;
  // Keep write queue space for every read still in flight
  assign rd_room  = (write_count + rd_outstanding) < (`HC_WRITE_DEPTH - 4);
  assign rd_issue = (rd_state == rd_stream) && !host_rx.c0_alm_full && rd_room;
  assign rd_last  = ((rd_count + 1'b1) == t_addr'(rd_req.arg.size));

  always_comb begin
    rd_next = rd_state;
    case (rd_state)
      rd_idle: begin
        if (read_not_empty && (read_head.arg.size != '0)) begin
          rd_next = rd_stream;
        end
      end
      rd_stream: begin
        if (rd_issue && rd_last) begin
          rd_next = rd_idle;
        end
      end
      default: rd_next = rd_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state       <= rd_idle;
      rd_req         <= '0;
      rd_count       <= '0;
      rd_outstanding <= '0;
      c0_valid       <= 1'b0;
    end
    else begin
      rd_state <= rd_next;
      c0_valid <= rd_issue;
      if (read_deq_en) begin
        rd_req   <= read_head;
        rd_count <= '0;
      end
      else if (rd_issue) begin
        rd_count <= rd_count + 1'b1;
      end
      case ({rd_issue, host_rx.rsp_valid})
        2'b10:   rd_outstanding <= rd_outstanding + 1'b1;
        2'b01:   rd_outstanding <= rd_outstanding - 1'b1;
        default: rd_outstanding <= rd_outstanding;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_issue) begin
      c0_address <= hc_buffer[rd_req.id].address + rd_count;
    end
  end

  assign c0_tx = '{valid: c0_valid, address: c0_address};

  // ========================================
  // Read response forwarding
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end
    else begin
      rsp_valid_q <= host_rx.rsp_valid;  // One cycle pulse per response
    end
  end

  always_ff @(posedge clk) begin
    if (host_rx.rsp_valid) begin
      rsp_data_q <= host_rx.rsp_data;
    end
  end

  assign core_rx = '{valid: rsp_valid_q, data: rsp_data_q};

  // ========================================
  // Write FSM and DSM completion
  // ========================================
  assign wr_issue     = (wr_state == wr_run) && !host_rx.c1_alm_full && write_not_empty;
  assign write_deq_en = wr_issue;
  assign dsm_issue    = (wr_state == wr_finish) && !host_rx.c1_alm_full;

  always_comb begin
    wr_next = wr_state;
    case (wr_state)
      wr_idle: begin
        if (control_start) begin
          wr_next = wr_run;
        end
      end
      wr_run: begin
        if (finish && !write_not_empty) begin
          wr_next = wr_finish;  // Every data write already issued
        end
      end
      wr_finish: begin
        if (dsm_issue) begin
          wr_next = wr_done;
        end
      end
      wr_done: begin
        if (!control_start) begin
          wr_next = wr_idle;
        end
      end
      default: wr_next = wr_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state  <= wr_idle;
      wr_offset <= '0;
      c1_valid  <= 1'b0;
    end
    else begin
      wr_state <= wr_next;
      c1_valid <= wr_issue || dsm_issue;
      if (wr_state == wr_idle) begin
        wr_offset <= '0;
      end
      else if (wr_issue) begin
        if (write_head.cmd == e_REQUEST_WRITE_STREAM) begin
          wr_offset <= wr_offset + 1'b1;
        end
        else begin
          wr_offset <= t_addr'(write_head.offset) + 1'b1;  // Stream resumes after index
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_issue) begin
      c1_data <= write_head.data;
      if (write_head.cmd == e_REQUEST_WRITE_STREAM) begin
        c1_address <= hc_buffer[write_head.id].address + wr_offset;
      end
      else begin
        c1_address <= hc_buffer[write_head.id].address + t_addr'(write_head.offset);
      end
    end
    else if (dsm_issue) begin
      c1_address <= hc_dsm_base;
      c1_data    <= t_line'(1);
    end
  end

  assign c1_tx = '{valid: c1_valid, address: c1_address, data: c1_data};

endmodule

// ==== logic/hc_copy_core.sv ====
// Copies buffer 0 into buffer 1 once per rising start and expects reverse to stay stable in a run
`timescale 1ns/1ns
`include "hc_params.svh"

module hc_copy_core (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     reverse,
  input  hc_pkg::t_hc_buffer       hc_buffer [`HC_BUFFER_COUNT],
  input  hc_pkg::t_core_rx         core_rx,
  input  hc_pkg::t_queue_status    read_status,
  input  hc_pkg::t_queue_status    write_status,
  output hc_pkg::t_request_control read_request,
  output hc_pkg::t_request_control write_request,
  output hc_pkg::t_line            write_data,
  output logic                     finish
);

  import hc_pkg::*;

  localparam t_buffer_id src_id = t_buffer_id'(0);
  localparam t_buffer_id dst_id = t_buffer_id'(1);

  logic        start_d;
  logic        start_rise;
  logic        launch;   // Stream read still to be queued
  logic        running;
  t_line_count size;
  t_line_count count;    // Lines returned so far

  assign start_rise = start && !start_d;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start_d       <= 1'b0;
      launch        <= 1'b0;
      running       <= 1'b0;
      size          <= '0;
      count         <= '0;
      finish        <= 1'b0;
      read_request  <= '0;
      write_request <= '0;
    end
    else begin
      start_d           <= start;
      read_request.cmd  <= e_REQUEST_NONE;
      write_request.cmd <= e_REQUEST_NONE;

      if (start_rise) begin
        launch  <= 1'b1;
        running <= 1'b1;
        size    <= hc_buffer[src_id].size;
        count   <= '0;
      end

      if (launch && !read_status.full && !write_status.full) begin
        read_request.cmd      <= e_REQUEST_READ_STREAM;
        read_request.id       <= src_id;
        read_request.arg.size <= size;
        launch                <= 1'b0;
      end

      if (running && core_rx.valid) begin
        if (reverse) begin
          write_request.cmd <= e_REQUEST_WRITE_INDEXED;
          write_request.arg.offset <= size - count - 1'b1;  // Line k lands at size-1-k
        end
        else begin
          write_request.cmd <= e_REQUEST_WRITE_STREAM;
          write_request.arg.offset <= count;
        end
        write_request.id <= dst_id;
        count            <= count + 1'b1;
      end

      // Registered so the last write is already queued when finish rises
      if (running && !launch && (count == size)) begin
        finish <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (core_rx.valid) begin
      write_data <= core_rx.data;
    end
  end

endmodule

// ==== logic/hc_top.sv ====
// A run starts when hc_control holds the start value and ends with a write of 1 to the DSM line
`timescale 1ns/1ns
`include "hc_params.svh"

module hc_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [31:0]              hc_control,
  input  logic [`HC_ADDR_BITS-1:0] hc_dsm_base,
  input  hc_pkg::t_hc_buffer       hc_buffer [`HC_BUFFER_COUNT],
  input  logic                     reverse,
  input  hc_pkg::t_host_rx         host_rx,
  output hc_pkg::t_c0_tx           c0_tx,
  output hc_pkg::t_c1_tx           c1_tx
);

  import hc_pkg::*;

  logic             start;
  logic             finish;
  t_request_control read_request;
  t_request_control write_request;
  t_line            write_data;
  t_core_rx         core_rx;
  t_queue_status    read_status;
  t_queue_status    write_status;

  hc_requestor u_requestor (
    .clk           (clk),
    .reset         (reset),
    .finish        (finish),
    .hc_control    (hc_control),
    .hc_dsm_base   (hc_dsm_base),
    .hc_buffer     (hc_buffer),
    .host_rx       (host_rx),
    .read_request  (read_request),
    .write_request (write_request),
    .write_data    (write_data),
    .start         (start),
    .c0_tx         (c0_tx),
    .c1_tx         (c1_tx),
    .core_rx       (core_rx),
    .read_status   (read_status),
    .write_status  (write_status)
  );

  hc_copy_core u_core (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .reverse       (reverse),
    .hc_buffer     (hc_buffer),
    .core_rx       (core_rx),
    .read_status   (read_status),
    .write_status  (write_status),
    .read_request  (read_request),
    .write_request (write_request),
    .write_data    (write_data),
    .finish        (finish)
  );

endmodule

// ==== tests/hc_checker.sv ====
// Bound to hc_requestor and assumes no data line shares the DSM address
`timescale 1ns/1ns
`include "hc_params.svh"

module hc_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     start,
  input logic [`HC_ADDR_BITS-1:0] hc_dsm_base,
  input hc_pkg::t_host_rx         host_rx,
  input hc_pkg::t_c0_tx           c0_tx,
  input hc_pkg::t_c1_tx           c1_tx
);

  logic dsm_write;
  logic dsm_seen;  // DSM written while start still high
  int   failures = 0;  // Assertion failures so far

  assign dsm_write = c1_tx.valid && (c1_tx.address == hc_dsm_base);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dsm_seen <= 1'b0;
    end
    else if (!start) begin
      dsm_seen <= 1'b0;
    end
    else if (dsm_write) begin
      dsm_seen <= 1'b1;
    end
  end

  // ========================================
  // Host channel rules
  // ========================================
  reset_quiet: assert property (@(posedge clk) reset |=> !c0_tx.valid && !c1_tx.valid)
    else begin
      failures++;
      $error("request valid in the cycle after reset");
    end

  c0_stall: assert property (@(posedge clk) disable iff (reset)
    host_rx.c0_alm_full [*2] |=> !c0_tx.valid)
    else begin
      failures++;
      $error("c0 request issued under almost-full");
    end

  c1_stall: assert property (@(posedge clk) disable iff (reset)
    host_rx.c1_alm_full [*2] |=> !c1_tx.valid)
    else begin
      failures++;
      $error("c1 request issued under almost-full");
    end

  dsm_last: assert property (@(posedge clk) disable iff (reset) dsm_seen |-> !c1_tx.valid)
    else begin
      failures++;
      $error("c1 request after the DSM write");
    end

endmodule

// ==== tests/hc_tb.sv ====
// Host memory holds 1024 lines and answers reads in order after 1 to 4 cycles
`timescale 1ns/1ns
`include "hc_params.svh"

module hc_tb;

  import hc_pkg::*;

  localparam int    clk_period      = 10;
  localparam int    mem_lines       = 1024;
  localparam int    total_lines     = 8 + 8 + 24;  // Lines copied over all runs
  localparam int    watchdog_cycles = 200 * total_lines;
  localparam t_addr src_base        = 32'h100;
  localparam t_addr dst_base        = 32'h200;
  localparam t_addr dsm_base        = 32'h3c0;

  logic                     clk;
  logic                     reset;
  logic [31:0]              hc_control;
  logic [`HC_ADDR_BITS-1:0] hc_dsm_base;
  t_hc_buffer               hc_buffer [`HC_BUFFER_COUNT];
  logic                     reverse;
  t_host_rx                 host_rx;
  t_c0_tx                   c0_tx;
  t_c1_tx                   c1_tx;

  // Host memory model state
  t_line mem [mem_lines];
  logic  backpressure;
  t_addr read_log [$];  // c0 addresses in issue order
  int    data_writes;
  int    dsm_writes;
  int    late_writes;   // Data writes after the DSM write

  hc_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .hc_control  (hc_control),
    .hc_dsm_base (hc_dsm_base),
    .hc_buffer   (hc_buffer),
    .reverse     (reverse),
    .host_rx     (host_rx),
    .c0_tx       (c0_tx),
    .c1_tx       (c1_tx)
  );

  bind hc_requestor hc_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .hc_dsm_base (hc_dsm_base),
    .host_rx     (host_rx),
    .c0_tx       (c0_tx),
    .c1_tx       (c1_tx)
  );

  always #(clk_period / 2) clk = !clk;

  // ========================================
  // Helpers and compare tasks
  // ========================================
  function automatic t_line line_pattern(input t_addr address);
    return {address * 32'h9e3779b9, address ^ 32'h5a5aa5a5};
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic stop_on_assertion_failure();
    if (u_dut.u_requestor.u_checker.failures != 0) begin
      $display("A host channel assertion in the bound checker failed");
      abort_run();
    end
  endtask

  task automatic check_line(input t_line got, input t_line expected, input string name);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic check_addr(input t_addr got, input t_addr expected, input string name);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int expected, input string name);
    if (got != expected) begin
      $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    stop_on_assertion_failure();
  end

  // ========================================
  // Host memory model
  // ========================================
  initial begin : host_model
    t_addr  rsp_addr [$];
    longint rsp_due [$];
    longint cycle;
    longint due;
    cycle = 0;
    void'($urandom(32'h9cef438c));
    host_rx     <= '0;
    data_writes <= 0;
    dsm_writes  <= 0;
    late_writes <= 0;
    forever begin
      @(posedge clk);
      cycle++;
      if (reset) begin
        rsp_addr.delete();
        rsp_due.delete();
        read_log.delete();
        host_rx     <= '0;
        data_writes <= 0;
        dsm_writes  <= 0;
        late_writes <= 0;
      end
      else begin
        if (c0_tx.valid) begin
          if (c0_tx.address >= mem_lines) begin
            $display("c0 read outside host memory at address %h", c0_tx.address);
            abort_run();
          end
          else begin
            due = cycle + longint'($urandom_range(1, 4));
            if ((rsp_due.size() != 0) && (due <= rsp_due[$])) begin
              due = rsp_due[$] + 1;  // Responses stay in order
            end
            rsp_addr.push_back(c0_tx.address);
            rsp_due.push_back(due);
            read_log.push_back(c0_tx.address);
          end
        end
        host_rx.rsp_valid <= 1'b0;
        if ((rsp_due.size() != 0) && (rsp_due[0] <= cycle)) begin
          host_rx.rsp_valid <= 1'b1;
          host_rx.rsp_data  <= mem[rsp_addr[0]];
          void'(rsp_addr.pop_front());
          void'(rsp_due.pop_front());
        end
        if (c1_tx.valid) begin
          if (c1_tx.address >= mem_lines) begin
            $display("c1 write outside host memory at address %h", c1_tx.address);
            abort_run();
          end
          else begin
            mem[c1_tx.address] <= c1_tx.data;
            if (c1_tx.address == dsm_base) begin
              dsm_writes <= dsm_writes + 1;
            end
            else begin
              data_writes <= data_writes + 1;
              if (dsm_writes != 0) begin
                late_writes <= late_writes + 1;
              end
            end
          end
        end
        if (backpressure) begin
          if ($urandom_range(0, 3) == 0) begin
            host_rx.c0_alm_full <= !host_rx.c0_alm_full;
          end
          if ($urandom_range(0, 3) == 0) begin
            host_rx.c1_alm_full <= !host_rx.c1_alm_full;
          end
        end
        else begin
          host_rx.c0_alm_full <= 1'b0;
          host_rx.c1_alm_full <= 1'b0;
        end
      end
    end
  end

  // ========================================
  // Directed tests
  // ========================================
  task automatic apply_reset();
    reset      <= 1'b1;
    hc_control <= '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic copy_lines(input t_line_count size, input logic rev, input logic bp);
    int    a;
    int    k;
    t_addr index;
    @(posedge clk);
    reverse      <= rev;
    backpressure <= bp;
    hc_buffer[0] <= '{address: src_base, size: size};
    hc_buffer[1] <= '{address: dst_base, size: size};
    for (a = 0; a < mem_lines; a++) begin
      mem[a] = ((a >= src_base) && (a < src_base + size)) ? line_pattern(t_addr'(a)) : '0;
    end
    apply_reset();
    @(posedge clk);
    hc_control <= `HC_CONTROL_START;
    while (dsm_writes == 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);  // Catch any stray request after completion
    check_count(data_writes, int'(size), "data write count");
    check_count(dsm_writes, 1, "DSM write count");
    check_count(late_writes, 0, "data writes after DSM");
    check_line(mem[dsm_base], t_line'(1), "DSM line");
    check_count(read_log.size(), int'(size), "c0 request count");
    for (k = 0; k < size; k++) begin
      check_addr(read_log[k], src_base + t_addr'(k), $sformatf("c0 address %0d", k));
      if (rev) begin
        index = dst_base + t_addr'(size) - 1 - t_addr'(k);  // Line k lands at size-1-k
      end
      else begin
        index = dst_base + t_addr'(k);
      end
      check_line(mem[index], line_pattern(src_base + t_addr'(k)),
                 $sformatf("mem[%0h]", index));
    end
    hc_control <= '0;
  endtask

  task automatic idle_after_reset();
    @(posedge clk);
    reverse      <= 1'b0;
    backpressure <= 1'b0;
    apply_reset();
    hc_control <= 32'h2;  // Not the start value
    repeat (50) @(posedge clk);
    check_count(read_log.size(), 0, "c0 requests after reset");
    check_count(data_writes + dsm_writes, 0, "c1 requests after reset");
    hc_control <= '0;
  endtask

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Run hung with no completion after %0d cycles", watchdog_cycles);
    abort_run();
  end

  initial begin
    clk          = 1'b0;
    reset        <= 1'b1;
    hc_control   <= '0;
    hc_dsm_base  <= dsm_base;
    hc_buffer    <= '{default: '0};
    reverse      <= 1'b0;
    backpressure <= 1'b0;
    copy_lines(16'd8, 1'b0, 1'b0);
    copy_lines(16'd8, 1'b1, 1'b0);
    copy_lines(16'd24, 1'b0, 1'b1);
    idle_after_reset();
    @(posedge clk);
    stop_on_assertion_failure();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== Bender.yml ====
package:
  name: hc_accel

sources:
  - include_dirs:
      - include
    files:
      - logic/hc_pkg.sv
      - logic/hc_fifo.sv
      - logic/hc_requestor.sv
      - logic/hc_copy_core.sv
      - logic/hc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/hc_checker.sv
      - tests/hc_tb.sv

// ==== all.f ====
+incdir+include
logic/hc_pkg.sv
logic/hc_fifo.sv
logic/hc_requestor.sv
logic/hc_copy_core.sv
logic/hc_top.sv
tests/hc_checker.sv
tests/hc_tb.sv
